//--- hw/arch_pkg.sv
package arch_pkg;

    // data path width
    localparam int xlen = 32;

    // register file geometry
    localparam int reg_idx_w = 5;
    localparam int num_regs  = 32;

    // shifts only look at the low bits of source 2
    localparam int shamt_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage

//--- hw/uop_pkg.sv
package uop_pkg;

    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        nor_op,
        sll,
        srl,
        sra
    } alu_op_e;

    // decoded micro-op as it arrives from issue
    typedef struct packed {
        alu_op_e            alu_op;
        logic               use_imm;
        logic               wen;
        arch_pkg::reg_idx_t rd;
        arch_pkg::reg_idx_t rj;
        arch_pkg::reg_idx_t rk;
        arch_pkg::word_t    imm;
    } uop_t;

    // REG-EXE0 contents
    typedef struct packed {
        logic            valid;
        uop_t            uop;
        arch_pkg::word_t rj_val;
        arch_pkg::word_t rk_val;
    } rr_rec_t;

    // shared by EXE0-EXE1 and EXE1-WB
    typedef struct packed {
        logic               valid;
        logic               wen;
        arch_pkg::reg_idx_t rd;
        arch_pkg::word_t    result;
    } ex_rec_t;

endpackage

//--- hw/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               rstn,
    input  logic               hold,
    input  uop_pkg::ex_rec_t   wb,
    input  arch_pkg::reg_idx_t rj_addr,
    input  arch_pkg::reg_idx_t rk_addr,
    output arch_pkg::word_t    rj_data,
    output arch_pkg::word_t    rk_data
);

    arch_pkg::word_t regs [arch_pkg::num_regs];
    logic            wr_en;

    // r0 is never written, so it stays at its reset value of zero
    assign wr_en = wb.valid && wb.wen && (wb.rd != '0) && !hold;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < arch_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // write-through covers the op three ahead
    always_comb begin
        rj_data = regs[rj_addr];
        rk_data = regs[rk_addr];
        if (wr_en && (wb.rd == rj_addr)) begin
            rj_data = wb.result;
        end
        if (wr_en && (wb.rd == rk_addr)) begin
            rk_data = wb.result;
        end
    end

endmodule

//--- hw/regread_stage.sv
module regread_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               hold,
    input  logic               issue_valid,
    input  uop_pkg::uop_t      issue_uop,
    output arch_pkg::reg_idx_t rj_addr,
    output arch_pkg::reg_idx_t rk_addr,
    input  arch_pkg::word_t    rj_data,
    input  arch_pkg::word_t    rk_data,
    output uop_pkg::rr_rec_t   rr
);

    // issue capture register (ID-REG)
    logic          iss_valid;
    uop_pkg::uop_t iss_uop;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            iss_valid <= 1'b0;
            iss_uop   <= '0;
        end else if (!hold) begin
            iss_valid <= issue_valid;
            iss_uop   <= issue_uop;
        end
    end

    // register file is read straight from the issue register
    assign rj_addr = iss_uop.rj;
    assign rk_addr = iss_uop.rk;

    // REG-EXE0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr <= '0;
        end else if (!hold) begin
            rr.valid  <= iss_valid;
            rr.uop    <= iss_uop;
            rr.rj_val <= rj_data;
            rr.rk_val <= rk_data;
        end
    end

endmodule

//--- hw/alu.sv
module alu (
    input  uop_pkg::alu_op_e op,
    input  arch_pkg::word_t  a,
    input  arch_pkg::word_t  b,
    output arch_pkg::word_t  result
);

    logic [arch_pkg::shamt_w-1:0] shamt;

    assign shamt = b[arch_pkg::shamt_w-1:0];

    always_comb begin
        case (op)
            uop_pkg::add:    result = a + b;
            uop_pkg::sub:    result = a - b;
            // compares give 0 or 1
            uop_pkg::slt:    result = arch_pkg::word_t'($signed(a) < $signed(b));
            uop_pkg::sltu:   result = arch_pkg::word_t'(a < b);
            uop_pkg::and_op: result = a & b;
            uop_pkg::or_op:  result = a | b;
            uop_pkg::xor_op: result = a ^ b;
            uop_pkg::nor_op: result = ~(a | b);
            uop_pkg::sll:    result = a << shamt;
            uop_pkg::srl:    result = a >> shamt;
            uop_pkg::sra:    result = arch_pkg::word_t'($signed(a) >>> shamt);
            // unused encodings
            default:         result = '0;
        endcase
    end

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic             clk,
    input  logic             rstn,
    input  logic             hold,
    input  uop_pkg::rr_rec_t rr,
    output uop_pkg::ex_rec_t wb
);

    uop_pkg::ex_rec_t ex0_ex1;
    uop_pkg::ex_rec_t ex1_wb;
    arch_pkg::word_t  rj_fwd;
    arch_pkg::word_t  rk_fwd;
    arch_pkg::word_t  src2;
    arch_pkg::word_t  alu_result;

    function automatic logic rec_hits(uop_pkg::ex_rec_t rec, arch_pkg::reg_idx_t src);
        return rec.valid && rec.wen && (rec.rd != '0) && (rec.rd == src);
    endfunction

    // nearest producer wins
    function automatic arch_pkg::word_t fwd_sel(
        arch_pkg::reg_idx_t src,
        arch_pkg::word_t    rf_val
    );
        if (rec_hits(ex0_ex1, src)) begin
            return ex0_ex1.result;
        end else if (rec_hits(ex1_wb, src)) begin
            return ex1_wb.result;
        end
        return rf_val;
    endfunction

    assign rj_fwd = fwd_sel(rr.uop.rj, rr.rj_val);
    assign rk_fwd = fwd_sel(rr.uop.rk, rr.rk_val);
    assign src2   = rr.uop.use_imm ? rr.uop.imm : rk_fwd;

    alu u_alu (
        .op     (rr.uop.alu_op),
        .a      (rj_fwd),
        .b      (src2),
        .result (alu_result)
    );

    // EXE0-EXE1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex0_ex1 <= '0;
        end else if (!hold) begin
            ex0_ex1.valid  <= rr.valid;
            ex0_ex1.wen    <= rr.uop.wen;
            ex0_ex1.rd     <= rr.uop.rd;
            ex0_ex1.result <= alu_result;
        end
    end

    // EXE1-WB
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex1_wb <= '0;
        end else if (!hold) begin
            ex1_wb <= ex0_ex1;
        end
    end

    assign wb = ex1_wb;

endmodule

//--- hw/cpu_core.sv
module cpu_core (
    input  logic               clk,
    input  logic               rstn,
    input  logic               issue_valid,
    input  uop_pkg::uop_t      issue_uop,
    input  logic               hold,
    output logic               wb_valid,
    output arch_pkg::reg_idx_t wb_rd,
    output arch_pkg::word_t    wb_data
);

    uop_pkg::rr_rec_t   rr;
    uop_pkg::ex_rec_t   wb;
    arch_pkg::reg_idx_t rj_addr;
    arch_pkg::reg_idx_t rk_addr;
    arch_pkg::word_t    rj_data;
    arch_pkg::word_t    rk_data;

    regread_stage u_regread (
        .clk         (clk),
        .rstn        (rstn),
        .hold        (hold),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .rj_addr     (rj_addr),
        .rk_addr     (rk_addr),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .rr          (rr)
    );

    execute_stage u_execute (
        .clk  (clk),
        .rstn (rstn),
        .hold (hold),
        .rr   (rr),
        .wb   (wb)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rstn    (rstn),
        .hold    (hold),
        .wb      (wb),
        .rj_addr (rj_addr),
        .rk_addr (rk_addr),
        .rj_data (rj_data),
        .rk_data (rk_data)
    );

    // writeback record out to the ports
    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.result;

endmodule

//--- include/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// reference result for one ALU operation
function automatic arch_pkg::word_t model_alu(
    uop_pkg::alu_op_e op,
    arch_pkg::word_t  a,
    arch_pkg::word_t  b
);
    int unsigned     sh;
    arch_pkg::word_t ones;
    sh   = b % arch_pkg::xlen;
    ones = '1;
    case (op)
        uop_pkg::add:    return a + b;
        uop_pkg::sub:    return a - b;
        uop_pkg::slt: begin
            // differing signs decide on their own
            if (a[arch_pkg::xlen-1] != b[arch_pkg::xlen-1]) begin
                return arch_pkg::word_t'(a[arch_pkg::xlen-1]);
            end
            return (a < b) ? 1 : 0;
        end
        uop_pkg::sltu:   return (a < b) ? 1 : 0;
        uop_pkg::and_op: return a & b;
        uop_pkg::or_op:  return a | b;
        uop_pkg::xor_op: return a ^ b;
        uop_pkg::nor_op: return ~(a | b);
        uop_pkg::sll:    return a << sh;
        uop_pkg::srl:    return a >> sh;
        uop_pkg::sra: begin
            // sign bit fills the vacated top positions
            if (a[arch_pkg::xlen-1]) begin
                return (a >> sh) | ~(ones >> sh);
            end
            return a >> sh;
        end
        default:         return '0;
    endcase
endfunction

// next value of the stimulus generator
function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- verif/tb_cpu_core.sv
module tb_cpu_core;

    localparam int num_rows   = 29;
    localparam int rand_ops   = 200;
    localparam int max_cycles = (num_rows + rand_ops) * 6 + 100;

    // one directed row holds the op, the hold cycles before it and the hand-worked result
    typedef struct packed {
        uop_pkg::uop_t   uop;
        logic [1:0]      hold_n;
        arch_pkg::word_t exp;
    } row_t;

    // one op in flight as the reference model sees it
    typedef struct packed {
        arch_pkg::reg_idx_t rd;
        arch_pkg::word_t    data;
        logic               has_tbl;
        arch_pkg::word_t    tbl_data;
        logic [31:0]        stamp;
    } exp_t;

    logic               clk;
    logic               rstn;
    logic               issue_valid;
    uop_pkg::uop_t      issue_uop;
    logic               hold;
    logic               wb_valid;
    arch_pkg::reg_idx_t wb_rd;
    arch_pkg::word_t    wb_data;
    logic               tbl_valid;
    arch_pkg::word_t    tbl_data;

    row_t            rows [num_rows];
    exp_t            exp_q [$];
    arch_pkg::word_t ref_regs [arch_pkg::num_regs];
    logic [31:0]     lcg_state;
    logic [31:0]     adv_cnt;
    int              cycle_cnt;
    int              issued;
    int              retired;
    int              val_errs;
    int              other_errs;

    `include "tb_alu_model.svh"

    cpu_core dut (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .hold        (hold),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #10 clk = ~clk;

    function automatic row_t mk_row(uop_pkg::alu_op_e op, int use_imm, int wen, int rd, int rj,
                                    int rk, arch_pkg::word_t imm, int hold_n,
                                    arch_pkg::word_t exp);
        row_t r;
        r.uop.alu_op  = op;
        r.uop.use_imm = (use_imm != 0);
        r.uop.wen     = (wen != 0);
        r.uop.rd      = arch_pkg::reg_idx_t'(rd);
        r.uop.rj      = arch_pkg::reg_idx_t'(rj);
        r.uop.rk      = arch_pkg::reg_idx_t'(rk);
        r.uop.imm     = imm;
        r.hold_n      = 2'(hold_n);
        r.exp         = exp;
        return r;
    endfunction

    // op, imm, wen, rd, rj, rk, imm value, holds, result
    task automatic load_table();
        rows[0]  = mk_row(uop_pkg::add,    1, 1,  1,  0,  0, 32'h0000_0005, 0, 32'h0000_0005);
        rows[1]  = mk_row(uop_pkg::add,    1, 1,  2,  0,  0, 32'hffff_fff0, 0, 32'hffff_fff0);
        rows[2]  = mk_row(uop_pkg::add,    0, 1,  3,  1,  2, 32'h0000_0000, 0, 32'hffff_fff5);
        rows[3]  = mk_row(uop_pkg::sub,    0, 1,  4,  3,  1, 32'h0000_0000, 0, 32'hffff_fff0);
        rows[4]  = mk_row(uop_pkg::slt,    0, 1,  5,  2,  1, 32'h0000_0000, 0, 32'h0000_0001);
        rows[5]  = mk_row(uop_pkg::sltu,   0, 1,  6,  2,  1, 32'h0000_0000, 0, 32'h0000_0000);
        rows[6]  = mk_row(uop_pkg::slt,    1, 1,  7,  1,  0, 32'hffff_ffff, 0, 32'h0000_0000);
        rows[7]  = mk_row(uop_pkg::sltu,   1, 1,  7,  1,  0, 32'hffff_ffff, 0, 32'h0000_0001);
        rows[8]  = mk_row(uop_pkg::and_op, 1, 1,  8,  2,  0, 32'h0000_ff0f, 0, 32'h0000_ff00);
        rows[9]  = mk_row(uop_pkg::or_op,  0, 1,  9,  8,  1, 32'h0000_0000, 0, 32'h0000_ff05);
        rows[10] = mk_row(uop_pkg::xor_op, 1, 1, 10,  9,  0, 32'hffff_0000, 0, 32'hffff_ff05);
        rows[11] = mk_row(uop_pkg::nor_op, 0, 1, 11,  1,  0, 32'h0000_0000, 0, 32'hffff_fffa);
        rows[12] = mk_row(uop_pkg::sll,    1, 1, 12,  1,  0, 32'h0000_001f, 0, 32'h8000_0000);
        rows[13] = mk_row(uop_pkg::sll,    1, 1, 13,  1,  0, 32'h0000_0021, 0, 32'h0000_000a);
        rows[14] = mk_row(uop_pkg::srl,    1, 1, 14,  2,  0, 32'h0000_0004, 0, 32'h0fff_ffff);
        rows[15] = mk_row(uop_pkg::sra,    1, 1, 15,  2,  0, 32'h0000_0004, 0, 32'hffff_ffff);
        rows[16] = mk_row(uop_pkg::sra,    0, 1, 16, 12,  1, 32'h0000_0000, 0, 32'hfc00_0000);
        rows[17] = mk_row(uop_pkg::srl,    0, 1, 17, 12,  3, 32'h0000_0000, 0, 32'h0000_0400);
        // r0 target shows on the bus but is never kept
        rows[18] = mk_row(uop_pkg::add,    1, 1,  0,  1,  0, 32'h0000_0064, 0, 32'h0000_0069);
        rows[19] = mk_row(uop_pkg::add,    0, 1, 18,  0,  1, 32'h0000_0000, 0, 32'h0000_0005);
        rows[20] = mk_row(uop_pkg::add,    0, 1, 19,  0,  0, 32'h0000_0000, 0, 32'h0000_0000);
        rows[21] = mk_row(uop_pkg::add,    1, 1, 20, 18,  0, 32'h0000_0001, 2, 32'h0000_0006);
        rows[22] = mk_row(uop_pkg::add,    0, 1, 21, 20, 20, 32'h0000_0000, 3, 32'h0000_000c);
        rows[23] = mk_row(uop_pkg::sub,    1, 1,  1, 21,  0, 32'h0000_000c, 1, 32'h0000_0000);
        rows[24] = mk_row(uop_pkg::add,    0, 1, 22,  1, 21, 32'h0000_0000, 0, 32'h0000_000c);
        // wen clear so r1 keeps its old value
        rows[25] = mk_row(uop_pkg::add,    1, 0,  1,  0,  0, 32'h0000_0007, 0, 32'h0000_0007);
        rows[26] = mk_row(uop_pkg::add,    1, 1, 23,  1,  0, 32'h0000_0001, 0, 32'h0000_0001);
        rows[27] = mk_row(uop_pkg::srl,    1, 1, 24,  2,  0, 32'h0000_0020, 0, 32'hffff_fff0);
        rows[28] = mk_row(uop_pkg::sra,    0, 1, 25, 12,  4, 32'h0000_0000, 1, 32'hffff_8000);
    endtask

    function automatic logic [31:0] draw();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // registers r0..r7 only, so dependencies are frequent
    function automatic uop_pkg::uop_t rand_uop(logic [31:0] r, logic [31:0] v);
        uop_pkg::uop_t u;
        u.alu_op  = uop_pkg::alu_op_e'(4'(r[31:24] % 8'd11));
        u.use_imm = r[23];
        u.wen     = (r[22:20] != 3'd0);
        u.rd      = {2'b00, r[19:17]};
        u.rj      = {2'b00, r[16:14]};
        u.rk      = {2'b00, r[13:11]};
        u.imm     = r[10] ? v : {{24{v[7]}}, v[7:0]};
        return u;
    endfunction

    task automatic issue_op(uop_pkg::uop_t u, logic has_tbl, arch_pkg::word_t tbl);
        @(posedge clk);
        hold        <= 1'b0;
        issue_valid <= 1'b1;
        issue_uop   <= u;
        tbl_valid   <= has_tbl;
        tbl_data    <= tbl;
    endtask

    // the core must ignore issue_valid while hold is high
    task automatic hold_cycle(logic junk_valid, uop_pkg::uop_t junk);
        @(posedge clk);
        hold        <= 1'b1;
        issue_valid <= junk_valid;
        issue_uop   <= junk;
        tbl_valid   <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        hold        <= 1'b0;
        issue_valid <= 1'b0;
        tbl_valid   <= 1'b0;
    endtask

    // reference model, advanced in issue order
    task automatic record_issue(uop_pkg::uop_t u);
        exp_t            e;
        arch_pkg::word_t b;
        b          = u.use_imm ? u.imm : ref_regs[u.rk];
        e.rd       = u.rd;
        e.data     = model_alu(u.alu_op, ref_regs[u.rj], b);
        e.has_tbl  = tbl_valid;
        e.tbl_data = tbl_data;
        e.stamp    = adv_cnt;
        exp_q.push_back(e);
        if (u.wen && (u.rd != '0)) begin
            ref_regs[u.rd] = e.data;
        end
        issued++;
    endtask

    task automatic check_writeback();
        exp_t e;
        assert (exp_q.size() != 0) else begin
            other_errs++;
            $display("writeback of rd %0d at time %0t with no op in flight", wb_rd, $time);
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            retired++;
            assert (wb_rd == e.rd && wb_data == e.data) else begin
                val_errs++;
                $display("CHECK FAILED at %0t: wb rd %0d data %h, model rd %0d data %h",
                         $time, wb_rd, wb_data, e.rd, e.data);
            end
            if (e.has_tbl) begin
                assert (wb_data == e.tbl_data) else begin
                    val_errs++;
                    $display("CHECK FAILED at %0t: wb data %h, table expects %h",
                             $time, wb_data, e.tbl_data);
                end
            end
            // accepted at edge N, counted at the fourth unheld edge after it
            assert (adv_cnt == e.stamp + 32'd4) else begin
                val_errs++;
                $display("CHECK FAILED at %0t: rd %0d counted %0d unheld edges after issue",
                         $time, wb_rd, adv_cnt - e.stamp);
            end
        end
    endtask

    // samples the values from before the edge
    always @(posedge clk) begin
        if (rstn) begin
            if (wb_valid && !hold) begin
                check_writeback();
            end
            if (issue_valid && !hold) begin
                record_issue(issue_uop);
            end
            if (!hold) begin
                adv_cnt = adv_cnt + 32'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        int          drain;
        clk         = 1'b0;
        rstn        = 1'b0;
        issue_valid = 1'b0;
        issue_uop   = '0;
        hold        = 1'b0;
        tbl_valid   = 1'b0;
        tbl_data    = '0;
        lcg_state   = 32'hcf0d;
        adv_cnt     = '0;
        cycle_cnt   = 0;
        issued      = 0;
        retired     = 0;
        val_errs    = 0;
        other_errs  = 0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        load_table();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            repeat (rows[i].hold_n) hold_cycle(1'b0, '0);
            issue_op(rows[i].uop, 1'b1, rows[i].exp);
        end

        // random stream with bubbles and holds mixed in
        for (int i = 0; i < rand_ops; i++) begin
            r = draw();
            if (r[31:29] == 3'd0) begin
                v = draw();
                hold_cycle(r[28], rand_uop(v, r));
            end
            if (r[27:25] == 3'd0) begin
                idle_cycle();
            end
            r = draw();
            v = draw();
            issue_op(rand_uop(r, v), 1'b0, '0);
        end
        idle_cycle();

        // the last op needs four unheld edges to be counted
        @(negedge clk);
        drain = 0;
        while (exp_q.size() != 0 && drain < 8) begin
            @(negedge clk);
            drain++;
        end
        repeat (6) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("%0d ops were issued but only %0d were written back", issued, retired);
        end

        $display("error counts: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hw/arch_pkg.sv
hw/uop_pkg.sv
hw/reg_file.sv
hw/regread_stage.sv
hw/alu.sv
hw/execute_stage.sv
hw/cpu_core.sv
verif/tb_cpu_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run tb_cpu_core with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module tb_cpu_core -f compile.f --Mdir obj_dir -o tb_cpu_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    exit 1
fi
exit 0
